//--- Bender.yml
package:
  name: fft_accel

sources:
  - src/fftPkg.sv
  - src/streamFifo.sv
  - src/fftControl.sv
  - src/butterfly.sv
  - src/fftCore.sv
  - src/fftAccel.sv
  - target: test
    files:
      - verification/fftAccelTb.sv

//--- sim.f
src/fftPkg.sv
src/streamFifo.sv
src/fftControl.sv
src/butterfly.sv
src/fftCore.sv
src/fftAccel.sv
verification/fftAccelTb.sv

//--- src/butterfly.sv
`default_nettype none

module butterfly (
    input  wire          clk,
    input  wire          rst,
    input  wire fftPkg::cplx a,
    input  wire fftPkg::cplx b,
    input  wire fftPkg::cplx w,
    input  wire          conj,
    output fftPkg::cplx  top,
    output fftPkg::cplx  bottom
);

    logic signed [15:0] wIm;
    logic signed [32:0] prodRe;
    logic signed [32:0] prodIm;
    logic signed [17:0] bwRe;
    logic signed [17:0] bwIm;
    logic signed [17:0] sumRe;
    logic signed [17:0] sumIm;
    logic signed [17:0] diffRe;
    logic signed [17:0] diffIm;

    // Inverse transform uses conj(w)
    assign wIm = conj ? -$signed(w.im) : $signed(w.im);

    always_comb begin
        prodRe = $signed(b.re) * $signed(w.re) - $signed(b.im) * wIm;
        prodIm = $signed(b.re) * wIm + $signed(b.im) * $signed(w.re);
        // Round half up back to Q1.15
        bwRe = 18'((prodRe + 33'sd16384) >>> 15);
        bwIm = 18'((prodIm + 33'sd16384) >>> 15);
        sumRe = $signed(a.re) + bwRe;
        sumIm = $signed(a.im) + bwIm;
        diffRe = $signed(a.re) - bwRe;
        diffIm = $signed(a.im) - bwIm;
    end

    ///////////////////////////////
    // Halve and register
    ///////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            top <= '0;
            bottom <= '0;
        end else begin
            top.re <= sumRe[16:1];
            top.im <= sumIm[16:1];
            bottom.re <= diffRe[16:1];
            bottom.im <= diffIm[16:1];
        end
    end

endmodule

`default_nettype wire

//--- src/fftAccel.sv
`default_nettype none

module fftAccel #(
    parameter int POINTS = 8,
    parameter int FIFO_DEPTH = 4
) (
    input  wire                clk,
    input  wire                rst,
    input  wire                startF,
    input  wire                startI,
    input  wire                inWrite,
    input  wire fftPkg::sampleWord inData,
    output logic               inFull,
    input  wire                outRead,
    output fftPkg::sampleWord  outData,
    output logic               outValid,
    output logic               calculating,
    output logic               aDone
);

    fftPkg::sampleWord inWord;
    fftPkg::sampleWord outWord;
    logic inFifoEmpty;
    logic outFifoFull;
    logic outFifoEmpty;
    logic popIn;
    logic pushOut;
    logic loadExternal;
    logic loadInternal;
    logic isIFFT;
    logic loadOutBuffer;
    logic loadExternalDone;
    logic done;
    logic outLoadDone;

    assign outValid = !outFifoEmpty;

    streamFifo #(.FIFO_DEPTH(FIFO_DEPTH)) inFifo (
        .clk       (clk),
        .rst       (rst),
        .write     (inWrite),
        .writeData (inData),
        .read      (popIn),
        .readData  (inWord),
        .full      (inFull),
        .empty     (inFifoEmpty)
    );

    fftControl control (
        .clk                 (clk),
        .rst                 (rst),
        .startF              (startF),
        .startI              (startI),
        .startLoadingRam     (!inFifoEmpty),
        .inFifoEmpty         (inFifoEmpty),
        .loadExternalDone    (loadExternalDone),
        .done                (done),
        .outFifoReady        (outFifoFull),
        .startLoadingOutFifo (!outFifoFull),
        .outLoadDone         (outLoadDone),
        .calculating         (calculating),
        .loadExternal        (loadExternal),
        .loadInternal        (loadInternal),
        .isIFFT              (isIFFT),
        .loadOutBuffer       (loadOutBuffer),
        .aDone               (aDone)
    );

    fftCore #(.POINTS(POINTS)) core (
        .clk              (clk),
        .rst              (rst),
        .loadExternal     (loadExternal),
        .loadInternal     (loadInternal),
        .isIFFT           (isIFFT),
        .loadOutBuffer    (loadOutBuffer),
        .calculating      (calculating),
        .inFifoEmpty      (inFifoEmpty),
        .inWord           (inWord),
        .outFifoFull      (outFifoFull),
        .popIn            (popIn),
        .pushOut          (pushOut),
        .outWord          (outWord),
        .loadExternalDone (loadExternalDone),
        .done             (done),
        .outLoadDone      (outLoadDone)
    );

    streamFifo #(.FIFO_DEPTH(FIFO_DEPTH)) outFifo (
        .clk       (clk),
        .rst       (rst),
        .write     (pushOut),
        .writeData (outWord),
        .read      (outRead),
        .readData  (outData),
        .full      (outFifoFull),
        .empty     (outFifoEmpty)
    );

endmodule

`default_nettype wire

//--- src/fftControl.sv
`default_nettype none

module fftControl (
    input  wire  clk,
    input  wire  rst,
    input  wire  startF,
    input  wire  startI,
    input  wire  startLoadingRam,
    input  wire  inFifoEmpty,
    input  wire  loadExternalDone,
    input  wire  done,
    input  wire  outFifoReady,
    input  wire  startLoadingOutFifo,
    input  wire  outLoadDone,
    output logic calculating,
    output logic loadExternal,
    output logic loadInternal,
    output logic isIFFT,
    output logic loadOutBuffer,
    output logic aDone
);

    typedef enum logic [3:0] {
        IDLE,
        LOADF,
        IDLE_LOADF,
        CALCULATINGF,
        LOADI,
        IDLE_LOADI,
        CALCULATINGI,
        LOADOUT,
        IDLE_LOADOUT,
        DONE
    } stateT;

    stateT state;
    stateT nextState;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= nextState;
        end
    end

    //////////////////////////////
    // Next state and outputs
    //////////////////////////////
    always_comb begin
        nextState = state;
        calculating = 1'b0;
        loadExternal = 1'b0;
        loadInternal = 1'b0;
        isIFFT = 1'b0;
        loadOutBuffer = 1'b0;
        aDone = 1'b0;

        case (state)
            IDLE: begin
                // Forward wins a tie
                if (startF) begin
                    nextState = LOADF;
                end else if (startI) begin
                    nextState = LOADI;
                end
            end

            // Forward input path
            LOADF: begin
                calculating = 1'b1;
                loadExternal = 1'b1;
                if (inFifoEmpty) nextState = IDLE_LOADF;
            end
            IDLE_LOADF: begin
                calculating = 1'b1;
                if (loadExternalDone) begin
                    nextState = CALCULATINGF;
                end else if (startLoadingRam) begin
                    nextState = LOADF;
                end
            end
            CALCULATINGF: begin
                calculating = 1'b1;
                loadInternal = 1'b1;
                if (done) nextState = LOADOUT;
            end

            // Inverse input path
            LOADI: begin
                calculating = 1'b1;
                loadExternal = 1'b1;
                if (inFifoEmpty) nextState = IDLE_LOADI;
            end
            IDLE_LOADI: begin
                calculating = 1'b1;
                if (loadExternalDone) begin
                    nextState = CALCULATINGI;
                end else if (startLoadingRam) begin
                    nextState = LOADI;
                end
            end
            CALCULATINGI: begin
                calculating = 1'b1;
                loadInternal = 1'b1;
                isIFFT = 1'b1;
                if (done) nextState = LOADOUT;
            end

            // Drain results into the output FIFO
            LOADOUT: begin
                calculating = 1'b1;
                loadOutBuffer = 1'b1;
                if (outFifoReady || outLoadDone) nextState = IDLE_LOADOUT;
            end
            IDLE_LOADOUT: begin
                calculating = 1'b1;
                if (outLoadDone) begin
                    nextState = DONE;
                end else if (startLoadingOutFifo) begin
                    nextState = LOADOUT;
                end
            end

            DONE: begin
                aDone = 1'b1;
                nextState = IDLE;
            end

            default: nextState = IDLE;
        endcase
    end

endmodule

`default_nettype wire

//--- src/fftCore.sv
`default_nettype none

module fftCore #(
    parameter int POINTS = 8
) (
    input  wire                clk,
    input  wire                rst,
    input  wire                loadExternal,
    input  wire                loadInternal,
    input  wire                isIFFT,
    input  wire                loadOutBuffer,
    input  wire                calculating,
    input  wire                inFifoEmpty,
    input  wire fftPkg::sampleWord inWord,
    input  wire                outFifoFull,
    output logic               popIn,
    output logic               pushOut,
    output fftPkg::sampleWord  outWord,
    output logic               loadExternalDone,
    output logic               done,
    output logic               outLoadDone
);

    localparam int log2Points = $clog2(POINTS);

    fftPkg::sampleWord mem [POINTS];
    wire fftPkg::cplx twTable [POINTS/2];

    logic [log2Points:0] loadCnt;
    logic [log2Points:0] unloadCnt;
    logic [log2Points-1:0] loadAddr;
    logic [log2Points-1:0] stage;
    logic [log2Points-1:0] bfly;
    logic [log2Points-1:0] half;
    logic [log2Points-1:0] idx;
    logic [log2Points-1:0] topAddr;
    logic [log2Points-1:0] botAddr;
    logic [log2Points-1:0] twFull;
    logic [log2Points-2:0] twIdx;
    logic [log2Points-1:0] wrTop;
    logic [log2Points-1:0] wrBot;
    logic bubble;
    logic finished;
    logic issue;
    logic wrEn;
    fftPkg::cplx btTop;
    fftPkg::cplx btBot;

    for (genvar i = 0; i < POINTS/2; i++) begin : genTwiddle
        assign twTable[i] = fftPkg::twiddle(i, POINTS);
    end

    ////////////////////////////////
    // Load and unload
    ////////////////////////////////
    assign loadExternalDone = (loadCnt == (log2Points+1)'(POINTS));
    assign outLoadDone = (unloadCnt == (log2Points+1)'(POINTS));
    assign popIn = loadExternal && !inFifoEmpty && !loadExternalDone;
    assign pushOut = loadOutBuffer && !outFifoFull && !outLoadDone;
    assign outWord = mem[unloadCnt[log2Points-1:0]];

    // Bit-reversed store address
    always_comb begin
        for (int i = 0; i < log2Points; i++) begin
            loadAddr[i] = loadCnt[log2Points-1-i];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            loadCnt <= '0;
            unloadCnt <= '0;
        end else if (!calculating) begin
            loadCnt <= '0;
            unloadCnt <= '0;
        end else begin
            if (popIn) loadCnt <= loadCnt + 1'b1;
            if (pushOut) unloadCnt <= unloadCnt + 1'b1;
        end
    end

    ////////////////////////////////
    // Butterfly sequencer
    ////////////////////////////////
    assign issue = loadInternal && !bubble && !finished;

    always_comb begin
        half = log2Points'(1) << stage;
        idx = bfly & (half - 1'b1);
        topAddr = ((bfly >> stage) << (stage + 1'b1)) | idx;
        botAddr = topAddr | half;
        twFull = idx << (log2Points - 1 - stage);
        twIdx = twFull[log2Points-2:0];
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stage <= '0;
            bfly <= '0;
            bubble <= 1'b0;
            finished <= 1'b0;
            wrEn <= 1'b0;
            done <= 1'b0;
        end else if (!loadInternal) begin
            stage <= '0;
            bfly <= '0;
            bubble <= 1'b0;
            finished <= 1'b0;
            wrEn <= 1'b0;
            done <= 1'b0;
        end else begin
            wrEn <= issue;
            done <= 1'b0;
            if (issue) begin
                if (bfly == log2Points'(POINTS/2 - 1)) begin
                    bfly <= '0;
                    bubble <= 1'b1;
                end else begin
                    bfly <= bfly + 1'b1;
                end
            end else if (bubble) begin
                // Last write of the stage lands during the bubble
                bubble <= 1'b0;
                if (stage == log2Points'(log2Points - 1)) begin
                    finished <= 1'b1;
                    done <= 1'b1;
                end else begin
                    stage <= stage + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            wrTop <= topAddr;
            wrBot <= botAddr;
        end
    end

    butterfly bf (
        .clk    (clk),
        .rst    (rst),
        .a      (mem[topAddr].c),
        .b      (mem[botAddr].c),
        .w      (twTable[twIdx]),
        .conj   (isIFFT),
        .top    (btTop),
        .bottom (btBot)
    );

    always_ff @(posedge clk) begin
        if (popIn) mem[loadAddr] <= inWord;
        if (wrEn) begin
            mem[wrTop].c <= btTop;
            mem[wrBot].c <= btBot;
        end
    end

endmodule

`default_nettype wire

//--- src/fftPkg.sv
`default_nettype none

package fftPkg;

    parameter int sampleWidth = 16;

    localparam real pi = 3.14159265358979;

    typedef struct packed {
        logic signed [sampleWidth-1:0] re;
        logic signed [sampleWidth-1:0] im;
    } cplx;

    // Raw view for the FIFOs, complex view for the math
    typedef union packed {
        logic [2*sampleWidth-1:0] raw;
        cplx c;
    } sampleWord;

    // Q1.15, nearest, with +1.0 clamped to the largest code
    function automatic logic signed [sampleWidth-1:0] toFixed(input real value);
        real scaled;
        scaled = value * 32767.0;
        return sampleWidth'($rtoi(scaled + ((scaled < 0.0) ? -0.5 : 0.5)));
    endfunction

    // W = cos(2*pi*k/n) - j*sin(2*pi*k/n)
    function automatic cplx twiddle(input int k, input int n);
        real angle;
        cplx result;
        angle = 2.0 * pi * k / n;
        result.re = toFixed($cos(angle));
        result.im = toFixed(-$sin(angle));
        return result;
    endfunction

endpackage

`default_nettype wire

//--- src/streamFifo.sv
`default_nettype none

module streamFifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  wire                clk,
    input  wire                rst,
    input  wire                write,
    input  wire fftPkg::sampleWord writeData,
    input  wire                read,
    output fftPkg::sampleWord  readData,
    output logic               full,
    output logic               empty
);

    localparam int ptrWidth = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int cntWidth = $clog2(FIFO_DEPTH + 1);

    fftPkg::sampleWord mem [FIFO_DEPTH];
    logic [ptrWidth-1:0] wrPtr;
    logic [ptrWidth-1:0] rdPtr;
    logic [cntWidth-1:0] count;
    logic doWrite;
    logic doRead;

    function automatic logic [ptrWidth-1:0] nextPtr(input logic [ptrWidth-1:0] ptr);
        return (ptr == ptrWidth'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full = (count == cntWidth'(FIFO_DEPTH));
    assign empty = (count == '0);
    assign doWrite = write && !full;
    assign doRead = read && !empty;

    // Head of the queue is always visible
    assign readData = mem[rdPtr];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doWrite) wrPtr <= nextPtr(wrPtr);
            if (doRead) rdPtr <= nextPtr(rdPtr);
            case ({doWrite, doRead})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (doWrite) mem[wrPtr] <= writeData;
    end

endmodule

`default_nettype wire

//--- verification/fftAccelTb.sv
`default_nettype none

module fftAccelTb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int POINTS = 8;
    localparam int FIFO_DEPTH = 4;
    localparam int NUM_TESTS = 7;
    localparam int FRAME_LIMIT = 40 * POINTS + 200;
    localparam real pi = 3.14159265358979;

    logic clk;
    logic rst;
    logic startF;
    logic startI;
    logic inWrite;
    fftPkg::sampleWord inData;
    logic inFull;
    logic outRead;
    fftPkg::sampleWord outData;
    logic outValid;
    logic calculating;
    logic aDone;

    // Stimulus table with expected bins
    string testName [NUM_TESTS];
    bit inverseTab [NUM_TESTS];
    bit gapTab [NUM_TESTS];
    bit stallTab [NUM_TESTS];
    bit midStartTab [NUM_TESTS];
    fftPkg::cplx xTab [NUM_TESTS][POINTS];
    fftPkg::cplx expTab [NUM_TESTS][POINTS];

    int errorCount;
    int testErrors;
    int testsRun;
    int testsFailed;
    bit timedOut;

    fftAccel #(.POINTS(POINTS), .FIFO_DEPTH(FIFO_DEPTH)) uut (
        .clk         (clk),
        .rst         (rst),
        .startF      (startF),
        .startI      (startI),
        .inWrite     (inWrite),
        .inData      (inData),
        .inFull      (inFull),
        .outRead     (outRead),
        .outData     (outData),
        .outValid    (outValid),
        .calculating (calculating),
        .aDone       (aDone)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    //////////////////////////////
    // Reference model
    //////////////////////////////
    function automatic logic signed [fftPkg::sampleWidth-1:0] quantize(input real v);
        real s;
        s = v * 32768.0;
        if (s > 32767.0) s = 32767.0;
        if (s < -32768.0) s = -32768.0;
        return 16'($rtoi(s + ((s < 0.0) ? -0.5 : 0.5)));
    endfunction

    function automatic fftPkg::cplx makeSample(input int re, input int im);
        fftPkg::cplx s;
        s.re = re[fftPkg::sampleWidth-1:0];
        s.im = im[fftPkg::sampleWidth-1:0];
        return s;
    endfunction

    // (1/N) sum x[n] exp(-+j 2 pi k n / N)
    function automatic fftPkg::cplx scaledDft(input int t, input int k);
        real sumRe;
        real sumIm;
        real xr;
        real xi;
        real ang;
        fftPkg::cplx r;
        sumRe = 0.0;
        sumIm = 0.0;
        for (int n = 0; n < POINTS; n++) begin
            xr = real'(int'(xTab[t][n].re)) / 32768.0;
            xi = real'(int'(xTab[t][n].im)) / 32768.0;
            ang = 2.0 * pi * real'(k * n) / real'(POINTS);
            if (!inverseTab[t]) ang = -ang;
            sumRe = sumRe + xr * $cos(ang) - xi * $sin(ang);
            sumIm = sumIm + xr * $sin(ang) + xi * $cos(ang);
        end
        r.re = quantize(sumRe / real'(POINTS));
        r.im = quantize(sumIm / real'(POINTS));
        return r;
    endfunction

    function automatic int smallRandom();
        return int'($urandom % 32'd16384) - 8192;
    endfunction

    task automatic setEntry(input int t, input string name, input bit inverse,
                            input bit gapped, input bit stall, input bit midStart);
        testName[t] = name;
        inverseTab[t] = inverse;
        gapTab[t] = gapped;
        stallTab[t] = stall;
        midStartTab[t] = midStart;
    endtask

    task automatic buildTable();
        int re;
        int im;
        setEntry(0, "impulse fwd", 1'b0, 1'b0, 1'b0, 1'b0);
        setEntry(1, "dc fwd gapped", 1'b0, 1'b1, 1'b0, 1'b0);
        setEntry(2, "alternating fwd", 1'b0, 1'b0, 1'b0, 1'b0);
        setEntry(3, "cosine fwd gapped", 1'b0, 1'b1, 1'b0, 1'b0);
        setEntry(4, "random fwd stalled", 1'b0, 1'b0, 1'b1, 1'b0);
        setEntry(5, "random inv mid-start", 1'b1, 1'b1, 1'b0, 1'b1);
        setEntry(6, "cosine inv stalled", 1'b1, 1'b0, 1'b1, 1'b0);
        for (int n = 0; n < POINTS; n++) begin
            xTab[0][n] = makeSample((n == 0) ? 29491 : 0, 0);
            xTab[1][n] = makeSample(16384, 0);
            xTab[2][n] = makeSample((n % 2 == 0) ? 16384 : -16384, 0);
            xTab[3][n] = makeSample(quantize(0.5 * $cos(2.0 * pi * n / POINTS)), 0);
            xTab[6][n] = xTab[3][n];
        end
        for (int t = 4; t <= 5; t++) begin
            for (int n = 0; n < POINTS; n++) begin
                re = smallRandom();
                im = smallRandom();
                xTab[t][n] = makeSample(re, im);
            end
        end
        for (int t = 0; t < NUM_TESTS; t++) begin
            for (int k = 0; k < POINTS; k++) begin
                expTab[t][k] = scaledDft(t, k);
            end
        end
    endtask

    //////////////////////////////
    // Checks
    //////////////////////////////
    task automatic checkSample(input fftPkg::cplx got, input fftPkg::cplx expected,
                               input int index);
        int dRe;
        int dIm;
        dRe = int'(got.re) - int'(expected.re);
        dIm = int'(got.im) - int'(expected.im);
        if (dRe < -POINTS || dRe > POINTS || dIm < -POINTS || dIm > POINTS) begin
            $display("mismatch at time %0t: bin %0d got (%0d, %0d) expected (%0d, %0d)",
                     $time, index, got.re, got.im, expected.re, expected.im);
            testErrors++;
        end
    endtask

    task automatic checkFrameEnd(input int count);
        if (count != 1) begin
            $display("mismatch at time %0t: %0d aDone pulses in one frame", $time, count);
            testErrors++;
        end
        if (calculating) begin
            $display("mismatch at time %0t: calculating still high after aDone", $time);
            testErrors++;
        end
    endtask

    task automatic checkIdleAfterReset();
        for (int c = 0; c < 20; c++) begin
            @(posedge clk);
            if (calculating || aDone || outValid) begin
                $display("mismatch at time %0t: calculating %b aDone %b outValid %b",
                         $time, calculating, aDone, outValid);
                testErrors++;
            end
        end
    endtask

    //////////////////////////////
    // Frame driver
    //////////////////////////////
    task automatic runFrame(input int t);
        int sent;
        int got;
        int held;
        int doneCount;
        int c;
        int startAt;
        bit accepted;
        bit calcDropped;
        sent = 0;
        got = 0;
        held = 0;
        doneCount = 0;
        c = 0;
        calcDropped = 1'b0;
        // Stalled frames also fill the input FIFO before the start strobe
        startAt = stallTab[t] ? -1 : 0;
        while (!(got == POINTS && doneCount > 0) && c < FRAME_LIMIT) begin
            @(posedge clk);
            // Nothing pops the input FIFO before the start
            if (startAt < 0 && inFull != (sent >= FIFO_DEPTH)) begin
                $display("mismatch at time %0t: inFull %b after %0d words before start",
                         $time, inFull, sent);
                testErrors++;
            end
            accepted = inWrite && !inFull;
            if (accepted) sent++;
            if (outRead && outValid) begin
                if (got < POINTS) begin
                    checkSample(outData.c, expTab[t][got], got);
                end else begin
                    $display("mismatch at time %0t: extra output word", $time);
                    testErrors++;
                end
                got++;
            end
            if (aDone) doneCount++;
            if (startAt >= 0 && c >= startAt + 2 && doneCount == 0) begin
                if (!aDone && !calculating) calcDropped = 1'b1;
            end
            if (stallTab[t] && outValid && held < 3 * POINTS) begin
                held++;
                if (held == 3 * POINTS && (!uut.outFifoFull || doneCount != 0)) begin
                    $display("output FIFO did not fill while outRead was held low");
                    testErrors++;
                end
            end

            if (startAt < 0 && inFull) startAt = c;
            startF <= (c == startAt) && !inverseTab[t];
            // Stray start in the middle of the frame
            startI <= ((c == startAt) && inverseTab[t]) ||
                      (midStartTab[t] && startAt >= 0 && c == startAt + 4);
            inWrite <= (sent < POINTS) && !(gapTab[t] && accepted);
            if (sent < POINTS) inData.c <= xTab[t][sent];
            outRead <= !stallTab[t] || held >= 3 * POINTS;
            c++;
        end
        inWrite <= 1'b0;
        if (c >= FRAME_LIMIT) begin
            $display("timeout: test %0d did not finish within %0d cycles", t, FRAME_LIMIT);
            timedOut = 1'b1;
            testErrors++;
        end else begin
            repeat (3) begin
                @(posedge clk);
                if (aDone) doneCount++;
            end
            if (calcDropped) begin
                $display("mismatch at time %0t: calculating fell before aDone", $time);
                testErrors++;
            end
            checkFrameEnd(doneCount);
        end
    endtask

    task automatic reportTest(input string name);
        testsRun++;
        errorCount += testErrors;
        if (testErrors == 0) begin
            $display("test %s: pass", name);
        end else begin
            testsFailed++;
            $display("test %s: fail with %0d errors", name, testErrors);
        end
    endtask

    initial begin
        void'($urandom(32'h51db40dd));
        rst = 1'b1;
        startF = 1'b0;
        startI = 1'b0;
        inWrite = 1'b0;
        inData = '0;
        outRead = 1'b1;
        errorCount = 0;
        testsRun = 0;
        testsFailed = 0;
        timedOut = 1'b0;
        buildTable();

        repeat (5) @(posedge clk);
        rst <= 1'b0;
        testErrors = 0;
        checkIdleAfterReset();
        reportTest("reset idle");

        for (int t = 0; t < NUM_TESTS && !timedOut; t++) begin
            testErrors = 0;
            runFrame(t);
            reportTest(testName[t]);
        end

        $display("tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errorCount);
        if (errorCount == 0 && !timedOut) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
